// File: dataflow_params.svh
/*
 * global sizes for the dataflow fragment
 */
`ifndef DATAFLOW_PARAMS_SVH
`define DATAFLOW_PARAMS_SVH

// width of every data token
`define DF_DATA_WIDTH 32

// operand count of a binary operator join
`define DF_BIN_INPUTS 2

`endif

// File: dataflow_pkg.sv
/*
 * token type, operator opcodes, comparison predicates
 * and the packed channel structs of the dataflow fragment
 */
`include "dataflow_params.svh"

package dataflow_pkg;

	// one data token
	typedef logic [`DF_DATA_WIDTH-1:0] data_t;

	// ------------------------------
	// integer operator opcodes
	// ------------------------------
	typedef enum logic [2:0] {
		OP_ADD  = 3'd0,
		OP_SUB  = 3'd1,
		OP_AND  = 3'd2,
		OP_OR   = 3'd3,
		OP_XOR  = 3'd4,
		OP_SHL  = 3'd5,
		OP_LSHR = 3'd6,
		OP_ASHR = 3'd7
	} alu_op_e;

	// ------------------------------
	// comparison predicates
	// ------------------------------
	typedef enum logic [3:0] {
		PRED_EQ  = 4'd0,
		PRED_NE  = 4'd1,
		PRED_UGT = 4'd2,
		PRED_UGE = 4'd3,
		PRED_ULT = 4'd4,
		PRED_ULE = 4'd5,
		PRED_SGT = 4'd6,
		PRED_SGE = 4'd7,
		PRED_SLT = 4'd8,
		PRED_SLE = 4'd9
	} cmp_pred_e;

	// left operand of the operator carries the opcode along
	typedef struct packed {
		alu_op_e op;
		data_t   value;
	} alu_lhs_t;

	// left operand of the comparison carries the predicate along
	typedef struct packed {
		cmp_pred_e pred;
		data_t     value;
	} cmp_lhs_t;

endpackage

// File: join_ctrl.sv
/*
 * N-input join of valid/ready channels
 */
`timescale 1ns/10ps

module join_ctrl #(
	parameter int N = 2
) (
	input  logic [N-1:0] valid_in,
	output logic [N-1:0] ready_in,
	output logic         valid_out,
	input  logic         ready_out
);

	// output token exists only once every input has one
	assign valid_out = &valid_in;

	// input i is granted when downstream takes the token and all others are there,
	// so every input transfers in the same cycle
	for (genvar i = 0; i < N; i++) begin : g_ready
		logic [N-1:0] others;

		assign others      = valid_in | (N'(1) << i);
		assign ready_in[i] = ready_out & (&others);
	end

endmodule

// File: alu_op.sv
/*
 * joined two-operand integer operator, function picked by the opcode
 * that travels with the left operand
 */
`timescale 1ns/10ps
`include "dataflow_params.svh"

module alu_op (
	input  dataflow_pkg::alu_lhs_t lhs,
	input  logic                   lhs_valid,
	output logic                   lhs_ready,
	input  dataflow_pkg::data_t    rhs,
	input  logic                   rhs_valid,
	output logic                   rhs_ready,
	output dataflow_pkg::data_t    res,
	output logic                   res_valid,
	input  logic                   res_ready
);

	import dataflow_pkg::*;

	logic [`DF_BIN_INPUTS-1:0] op_valid;
	logic [`DF_BIN_INPUTS-1:0] op_ready;

	// ------------------------------
	// handshake
	// ------------------------------
	assign op_valid  = {rhs_valid, lhs_valid};
	assign lhs_ready = op_ready[0];
	assign rhs_ready = op_ready[1];

	join_ctrl #(
		.N(`DF_BIN_INPUTS)
	) u_join (
		.valid_in (op_valid),
		.ready_in (op_ready),
		.valid_out(res_valid),
		.ready_out(res_ready)
	);

	// ------------------------------
	// datapath
	// ------------------------------
	// arithmetic wraps, shifts take the whole rhs word as the amount
	always_comb begin
		case (lhs.op)
			OP_ADD:  res = lhs.value + rhs;
			// lhs minus rhs
			OP_SUB:  res = lhs.value - rhs;
			OP_AND:  res = lhs.value & rhs;
			OP_OR:   res = lhs.value | rhs;
			OP_XOR:  res = lhs.value ^ rhs;
			// amounts of 32 and up clear the word
			OP_SHL:  res = lhs.value << rhs;
			OP_LSHR: res = lhs.value >> rhs;
			// sign fill for large amounts
			OP_ASHR: res = $signed(lhs.value) >>> rhs;
			default: res = '0;
		endcase
	end

endmodule

// File: icmp_op.sv
/*
 * joined two-operand integer comparison, predicate carried
 * with the left operand, answer zero-extended to a word
 */
`timescale 1ns/10ps
`include "dataflow_params.svh"

module icmp_op (
	input  dataflow_pkg::cmp_lhs_t lhs,
	input  logic                   lhs_valid,
	output logic                   lhs_ready,
	input  dataflow_pkg::data_t    rhs,
	input  logic                   rhs_valid,
	output logic                   rhs_ready,
	output dataflow_pkg::data_t    res,
	output logic                   res_valid,
	input  logic                   res_ready
);

	import dataflow_pkg::*;

	logic [`DF_BIN_INPUTS-1:0] op_valid;
	logic [`DF_BIN_INPUTS-1:0] op_ready;
	logic                      hit;

	assign op_valid  = {rhs_valid, lhs_valid};
	assign lhs_ready = op_ready[0];
	assign rhs_ready = op_ready[1];

	join_ctrl #(
		.N(`DF_BIN_INPUTS)
	) u_join (
		.valid_in (op_valid),
		.ready_in (op_ready),
		.valid_out(res_valid),
		.ready_out(res_ready)
	);

	// signed predicates read both words as two's complement
	always_comb begin
		case (lhs.pred)
			PRED_EQ:  hit = (lhs.value == rhs);
			PRED_NE:  hit = (lhs.value != rhs);
			PRED_UGT: hit = (lhs.value >  rhs);
			PRED_UGE: hit = (lhs.value >= rhs);
			PRED_ULT: hit = (lhs.value <  rhs);
			PRED_ULE: hit = (lhs.value <= rhs);
			PRED_SGT: hit = ($signed(lhs.value) >  $signed(rhs));
			PRED_SGE: hit = ($signed(lhs.value) >= $signed(rhs));
			PRED_SLT: hit = ($signed(lhs.value) <  $signed(rhs));
			PRED_SLE: hit = ($signed(lhs.value) <= $signed(rhs));
			// unused encodings answer false
			default:  hit = 1'b0;
		endcase
	end

	assign res = data_t'(hit);

endmodule

// File: antitoken_ctrl.sv
/*
 * pending antitoken flags of a select, one per operand side
 */
`timescale 1ns/10ps

module antitoken_ctrl (
	input  logic clk,
	input  logic rst,
	input  logic valid_t,
	input  logic valid_f,
	input  logic gen_t,
	input  logic gen_f,
	output logic kill_t,
	output logic kill_f,
	output logic stop
);

	logic pend_t;
	logic pend_f;

	// a flag lives until the next token on its side shows up and is eaten
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			pend_t <= 1'b0;
			pend_f <= 1'b0;
		end else begin
			pend_t <= ~valid_t & (gen_t | pend_t);
			pend_f <= ~valid_f & (gen_f | pend_f);
		end
	end

	// kill already in the generate cycle, so a token arriving then is dropped
	assign kill_t = gen_t | pend_t;
	assign kill_f = gen_f | pend_f;
	assign stop   = pend_t | pend_f;

	// an antitoken is only generated for a side that has no token yet
	a_gen_t_absent: assert property (@(posedge clk) disable iff (rst) !(gen_t && valid_t))
		else $error("antitoken_ctrl: gen_t while true operand valid");
	a_gen_f_absent: assert property (@(posedge clk) disable iff (rst) !(gen_f && valid_f))
		else $error("antitoken_ctrl: gen_f while false operand valid");

endmodule

// File: select_op.sv
/*
 * three-input select, condition plus true and false operands,
 * late unused operand discarded through antitokens
 */
`timescale 1ns/10ps

module select_op (
	input  logic                clk,
	input  logic                rst,
	input  dataflow_pkg::data_t cond,
	input  logic                cond_valid,
	output logic                cond_ready,
	input  dataflow_pkg::data_t tval,
	input  logic                tval_valid,
	output logic                tval_ready,
	input  dataflow_pkg::data_t fval,
	input  logic                fval_valid,
	output logic                fval_ready,
	output dataflow_pkg::data_t res,
	output logic                res_valid,
	input  logic                res_ready
);

	logic sel;
	logic chosen_valid;
	logic fire;
	logic gen_t;
	logic gen_f;
	logic kill_t;
	logic kill_f;
	logic stop;

	// only the lsb of the condition word matters
	assign sel          = cond[0];
	assign chosen_valid = sel ? tval_valid : fval_valid;

	// ------------------------------
	// firing
	// ------------------------------
	// held back while an earlier firing still owes a drop
	assign res_valid = cond_valid & chosen_valid & ~stop;
	assign fire      = res_valid & res_ready;
	assign res       = sel ? tval : fval;

	// the side that is missing at firing time gets an antitoken
	assign gen_t = fire & ~tval_valid;
	assign gen_f = fire & ~fval_valid;

	// ------------------------------
	// input readies
	// ------------------------------
	assign cond_ready = ~cond_valid | fire;
	assign tval_ready = ~tval_valid | fire | kill_t;
	assign fval_ready = ~fval_valid | fire | kill_f;

	antitoken_ctrl u_anti (
		.clk    (clk),
		.rst    (rst),
		.valid_t(tval_valid),
		.valid_f(fval_valid),
		.gen_t  (gen_t),
		.gen_f  (gen_f),
		.kill_t (kill_t),
		.kill_f (kill_f),
		.stop   (stop)
	);

	// a stalled result holds until the return stage takes it
	a_hold_when_stalled: assert property (@(posedge clk) disable iff (rst)
		res_valid && !res_ready |=> res_valid && $stable(res))
		else $error("select_op: result changed while stalled");

endmodule

// File: tehb.sv
/*
 * one-slot transparent elastic half buffer
 */
`timescale 1ns/10ps

module tehb (
	input  logic                clk,
	input  logic                rst,
	input  dataflow_pkg::data_t in_data,
	input  logic                in_valid,
	output logic                in_ready,
	output dataflow_pkg::data_t out_data,
	output logic                out_valid,
	input  logic                out_ready
);

	import dataflow_pkg::*;

	logic  full;
	data_t store;
	logic  capture;

	// grab the passing token when downstream stalls it
	assign capture = ~full & in_valid & ~out_ready;

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			full <= 1'b0;
		end else if (capture) begin
			full <= 1'b1;
		end else if (full && out_ready) begin
			full <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (capture) begin
			store <= in_data;
		end
	end

	// bypass while empty, stored token has priority
	assign in_ready  = ~full;
	assign out_valid = full | in_valid;
	assign out_data  = full ? store : in_data;

	// stalled output keeps its token until taken
	a_hold_on_stall: assert property (@(posedge clk) disable iff (rst)
		out_valid && !out_ready |=> out_valid && $stable(out_data))
		else $error("tehb: output changed while stalled");

endmodule

// File: dataflow_core.sv
/*
 * top of the fragment: operator, comparison, select and return buffer
 */
`timescale 1ns/10ps

module dataflow_core (
	input  logic                   clk,
	input  logic                   rst,
	input  dataflow_pkg::alu_lhs_t alu_lhs,
	input  logic                   alu_lhs_valid,
	output logic                   alu_lhs_ready,
	input  dataflow_pkg::data_t    alu_rhs,
	input  logic                   alu_rhs_valid,
	output logic                   alu_rhs_ready,
	input  dataflow_pkg::cmp_lhs_t cmp_lhs,
	input  logic                   cmp_lhs_valid,
	output logic                   cmp_lhs_ready,
	input  dataflow_pkg::data_t    cmp_rhs,
	input  logic                   cmp_rhs_valid,
	output logic                   cmp_rhs_ready,
	input  dataflow_pkg::data_t    alt,
	input  logic                   alt_valid,
	output logic                   alt_ready,
	output dataflow_pkg::data_t    result,
	output logic                   result_valid,
	input  logic                   result_ready
);

	import dataflow_pkg::*;

	// operator result feeds the true side of the select
	data_t alu_res;
	logic  alu_res_valid, alu_res_ready;
	// comparison result is the select condition
	data_t cmp_res;
	logic  cmp_res_valid, cmp_res_ready;
	data_t sel_res;
	logic  sel_res_valid, sel_res_ready;

	alu_op u_alu (
		.lhs(alu_lhs), .lhs_valid(alu_lhs_valid), .lhs_ready(alu_lhs_ready),
		.rhs(alu_rhs), .rhs_valid(alu_rhs_valid), .rhs_ready(alu_rhs_ready),
		.res(alu_res), .res_valid(alu_res_valid), .res_ready(alu_res_ready)
	);

	icmp_op u_cmp (
		.lhs(cmp_lhs), .lhs_valid(cmp_lhs_valid), .lhs_ready(cmp_lhs_ready),
		.rhs(cmp_rhs), .rhs_valid(cmp_rhs_valid), .rhs_ready(cmp_rhs_ready),
		.res(cmp_res), .res_valid(cmp_res_valid), .res_ready(cmp_res_ready)
	);

	select_op u_sel (
		.clk (clk), .rst(rst),
		.cond(cmp_res), .cond_valid(cmp_res_valid), .cond_ready(cmp_res_ready),
		.tval(alu_res), .tval_valid(alu_res_valid), .tval_ready(alu_res_ready),
		.fval(alt), .fval_valid(alt_valid), .fval_ready(alt_ready),
		.res (sel_res), .res_valid(sel_res_valid), .res_ready(sel_res_ready)
	);

	// ------------------------------
	// return stage
	// ------------------------------
	tehb u_ret (
		.clk     (clk), .rst(rst),
		.in_data (sel_res), .in_valid(sel_res_valid), .in_ready(sel_res_ready),
		.out_data(result), .out_valid(result_valid), .out_ready(result_ready)
	);

endmodule

// File: dataflow_core_tb.sv
/*
 * testbench for the dataflow fragment: random producers on the five
 * input channels, reference model queues and checking assertions
 */
`timescale 1ns/10ps
`include "dataflow_params.svh"

module dataflow_core_tb;

	import dataflow_pkg::*;

	localparam int W           = `DF_DATA_WIDTH;
	localparam int N_TOKENS    = 300;
	localparam int CYCLE_LIMIT = 20 * N_TOKENS + 200;

	logic       clk;
	logic       rst;
	alu_lhs_t   alu_lhs;
	data_t      alu_rhs;
	cmp_lhs_t   cmp_lhs;
	data_t      cmp_rhs;
	data_t      alt;
	// channel order 0 alu_lhs, 1 alu_rhs, 2 cmp_lhs, 3 cmp_rhs, 4 alt
	logic [4:0] in_valid;
	wire  [4:0] in_ready;
	data_t      result;
	logic       result_valid;
	logic       result_ready;

	// model queues, filled by the producers on each transfer
	alu_lhs_t alu_lhs_q[$];
	data_t    alu_rhs_q[$];
	cmp_lhs_t cmp_lhs_q[$];
	data_t    cmp_rhs_q[$];
	data_t    alt_q[$];
	// tokens still owed to an antitoken, per select side
	int       owe_alu, owe_alt;
	int       errors, results, cycles;
	logic     took, stalled, inputs_seen;
	data_t    took_val, held;

	dataflow_core dut (
		.clk(clk), .rst(rst),
		.alu_lhs(alu_lhs), .alu_lhs_valid(in_valid[0]), .alu_lhs_ready(in_ready[0]),
		.alu_rhs(alu_rhs), .alu_rhs_valid(in_valid[1]), .alu_rhs_ready(in_ready[1]),
		.cmp_lhs(cmp_lhs), .cmp_lhs_valid(in_valid[2]), .cmp_lhs_ready(in_ready[2]),
		.cmp_rhs(cmp_rhs), .cmp_rhs_valid(in_valid[3]), .cmp_rhs_ready(in_ready[3]),
		.alt(alt), .alt_valid(in_valid[4]), .alt_ready(in_ready[4]),
		.result(result), .result_valid(result_valid), .result_ready(result_ready)
	);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	// ------------------------------
	// stimulus
	// ------------------------------
	// edge values come up about half the time
	function automatic data_t pick_operand();
		case ($urandom_range(0, 7))
			0: return '0;
			1: return '1;
			2: return data_t'(1) << (W - 1);
			3: return data_t'($urandom_range(0, 3));
			default: return data_t'($urandom());
		endcase
	endfunction

	// one producer per input channel, random gaps between tokens
	task automatic produce(input int ch);
		for (int i = 0; i < N_TOKENS; i++) begin
			repeat ($urandom_range(0, 1) ? 0 : $urandom_range(1, 4)) @(negedge clk);
			case (ch)
				0: alu_lhs = '{op: alu_op_e'($urandom_range(0, 7)), value: pick_operand()};
				// shift amounts cluster around the word width
				1: alu_rhs = $urandom_range(0, 1) ? data_t'($urandom_range(30, 34))
				                                  : pick_operand();
				2: cmp_lhs = '{pred: cmp_pred_e'($urandom_range(0, 9)), value: pick_operand()};
				3: cmp_rhs = pick_operand();
				default: alt = pick_operand();
			endcase
			in_valid[ch] = 1'b1;
			@(posedge clk);
			while (!in_ready[ch])
				@(posedge clk);
			case (ch)
				0: alu_lhs_q.push_back(alu_lhs);
				1: alu_rhs_q.push_back(alu_rhs);
				2: cmp_lhs_q.push_back(cmp_lhs);
				3: cmp_rhs_q.push_back(cmp_rhs);
				default: alt_q.push_back(alt);
			endcase
			@(negedge clk);
			in_valid[ch] = 1'b0;
		end
	endtask

	// ------------------------------
	// reference model
	// ------------------------------
	// shifts go through a double-width word with the amount clipped at W
	function automatic data_t alu_expect(alu_op_e op, data_t a, data_t b);
		int unsigned amt;
		data_t       r;

		amt = (b > W) ? W : b;
		case (op)
			OP_ADD:  r = a + b;
			OP_SUB:  r = a + ~b + 1'b1;
			OP_AND:  r = a & b;
			OP_OR:   r = a | b;
			OP_XOR:  r = a ^ b;
			OP_SHL:  r = data_t'({{W{1'b0}}, a} << amt);
			OP_LSHR: r = data_t'({{W{1'b0}}, a} >> amt);
			OP_ASHR: r = data_t'({{W{a[W-1]}}, a} >> amt);
			default: r = '0;
		endcase
		return r;
	endfunction

	// signed order is unsigned order once the sign bits are flipped
	function automatic logic cmp_expect(cmp_pred_e pred, data_t a, data_t b);
		data_t sa, sb;

		sa = a ^ (data_t'(1) << (W - 1));
		sb = b ^ (data_t'(1) << (W - 1));
		case (pred)
			PRED_EQ:  return a == b;
			PRED_NE:  return a != b;
			PRED_UGT: return a > b;
			PRED_UGE: return a >= b;
			PRED_ULT: return a < b;
			PRED_ULE: return a <= b;
			PRED_SGT: return sa > sb;
			PRED_SGE: return sa >= sb;
			PRED_SLT: return sa < sb;
			PRED_SLE: return sa <= sb;
			default:  return 1'b0;
		endcase
	endfunction

	// ------------------------------
	// checking
	// ------------------------------
	always @(posedge clk) begin
		cycles++;
		took        = !rst && result_valid && result_ready;
		took_val    = result;
		inputs_seen = inputs_seen || (in_valid != '0);
		assert (!result_valid || inputs_seen) else begin
			$display("FAIL %0t result_valid: expected 0, got %b", $time, result_valid);
			errors++;
		end
		// joined operands transfer together
		assert ((in_valid[0] && in_ready[0]) == (in_valid[1] && in_ready[1])) else begin
			$display("operator operands transferred in different cycles at %0t", $time);
			errors++;
		end
		assert ((in_valid[2] && in_ready[2]) == (in_valid[3] && in_ready[3])) else begin
			$display("comparison operands transferred in different cycles at %0t", $time);
			errors++;
		end
		// a stalled result must hold until taken
		if (stalled) begin
			assert (result_valid) else begin
				$display("FAIL %0t result_valid: expected 1, got %b", $time, result_valid);
				errors++;
			end
			assert (result === held) else begin
				$display("FAIL %0t result: expected %h, got %h", $time, held, result);
				errors++;
			end
		end
		stalled = !rst && result_valid && !result_ready;
		held    = result;
		if (cycles >= CYCLE_LIMIT) begin
			$display("timeout after %0d cycles with %0d of %0d results, %0d errors", cycles,
				results, N_TOKENS, errors);
			$display("=== FAIL ===");
			$finish;
		end
	end

	// owed drops first, they belong to earlier firings
	always @(negedge clk) begin
		alu_lhs_t a;
		cmp_lhs_t c;
		data_t    expected;

		while (owe_alu > 0 && alu_lhs_q.size() > 0 && alu_rhs_q.size() > 0) begin
			void'(alu_lhs_q.pop_front());
			void'(alu_rhs_q.pop_front());
			owe_alu--;
		end
		while (owe_alt > 0 && alt_q.size() > 0) begin
			void'(alt_q.pop_front());
			owe_alt--;
		end
		if (took) begin
			results++;
			assert (cmp_lhs_q.size() > 0 && cmp_rhs_q.size() > 0) else begin
				$display("result at %0t with no condition token consumed", $time);
				errors++;
			end
			if (cmp_lhs_q.size() > 0 && cmp_rhs_q.size() > 0) begin
				c = cmp_lhs_q.pop_front();
				if (cmp_expect(c.pred, c.value, cmp_rhs_q.pop_front())) begin
					a        = alu_lhs_q.pop_front();
					expected = alu_expect(a.op, a.value, alu_rhs_q.pop_front());
					owe_alt++;
				end else begin
					expected = alt_q.pop_front();
					owe_alu++;
				end
				assert (took_val === expected) else begin
					$display("FAIL %0t result: expected %h, got %h", $time, expected, took_val);
					errors++;
				end
			end
		end
	end

	initial begin
		void'($urandom(18));
		rst          = 1'b1;
		in_valid     = '0;
		result_ready = 1'b0;
		alu_lhs      = '0;
		alu_rhs      = '0;
		cmp_lhs      = '0;
		cmp_rhs      = '0;
		alt          = '0;
		{errors, results, cycles, owe_alu, owe_alt} = '0;
		{took, stalled, inputs_seen} = '0;
		repeat (2) @(posedge clk);
		@(negedge clk);
		rst = 1'b0;
		fork
			forever begin
				@(negedge clk);
				result_ready = ($urandom_range(0, 3) != 0);
			end
		join_none
		fork
			produce(0);
			produce(1);
			produce(2);
			produce(3);
			produce(4);
		join
		// every condition token is in, let the return buffer drain
		wait (!result_valid);
		repeat (4) @(negedge clk);
		assert (results == N_TOKENS) else begin
			$display("%0d results for %0d condition tokens sent", results, N_TOKENS);
			errors++;
		end
		assert (alu_lhs_q.size() + alu_rhs_q.size() + cmp_lhs_q.size() + cmp_rhs_q.size()
			+ alt_q.size() == 0 && owe_alu == 0 && owe_alt == 0) else begin
			$display("tokens left over at the end, %0d alu, %0d cmp, %0d alt, %0d owed",
				alu_lhs_q.size(), cmp_lhs_q.size(), alt_q.size(), owe_alu + owe_alt);
			errors++;
		end
		$display("results %0d, cycles %0d, errors %0d", results, cycles, errors);
		if (errors == 0)
			$display("=== PASS ===");
		else
			$display("=== FAIL ===");
		$finish;
	end

endmodule

// File: compile.f
+incdir+.
dataflow_pkg.sv
join_ctrl.sv
alu_op.sv
icmp_op.sv
antitoken_ctrl.sv
select_op.sv
tehb.sv
dataflow_core.sv
dataflow_core_tb.sv
